// File: verilog/maze_grid_pkg.sv
package maze_grid_pkg;

    // playfield in cells
    localparam int grid_cols = 10;
    localparam int grid_rows = 15;

    // wall map layout
    localparam int h_row_bits = 10;  // one bit per column
    localparam int v_row_bits = 11;  // one more for the right border
    localparam int h_rows = 16;      // top border to bottom border
    localparam int v_rows = 15;
    localparam int v_base = 16;      // first word address of the vertical rows

    localparam int wall_addr_w = 5;

    // wall rules
    //   up    h row y,   bit x
    //   down  h row y+1, bit x
    //   left  v row y,   bit x
    //   right v row y,   bit x+1

    typedef logic [3:0]  cell_x_t;
    typedef logic [3:0]  cell_y_t;
    typedef logic [15:0] wb_data_t;  // wall row in the low bits

endpackage

// File: verilog/tft_link_pkg.sv
package tft_link_pkg;

    typedef logic [7:0] tft_byte_t;

    // panel commands
    localparam tft_byte_t cmd_col_addr  = 8'h2A;
    localparam tft_byte_t cmd_page_addr = 8'h2B;
    localparam tft_byte_t cmd_mem_write = 8'h2C;

    // one paint byte per cell
    localparam tft_byte_t colour_player = 8'hFF;
    localparam tft_byte_t colour_floor  = 8'h00;

    // each drawer state names the byte it sends next
    typedef enum logic [2:0] {
        idle,
        col_cmd,
        col_arg,
        page_cmd,
        page_arg,
        write_cmd,
        pixel
    } draw_state_t;

    typedef enum logic {
        spi_idle,
        spi_shift
    } spi_state_t;

endpackage

// File: verilog/button_sampler.sv
`timescale 1ns/1ps

// bits of buttons and move_req are 0 right, 1 down, 2 left, 3 up
module button_sampler (
    input  logic       clk,
    input  logic       rst,
    input  logic [3:0] buttons,   // active low
    output logic [3:0] move_req
);

    logic [3:0] sync_a;
    logic [3:0] sync_b;
    logic [3:0] prev;

    always_ff @(posedge clk) begin
        if (!rst) begin
            sync_a   <= '0;
            sync_b   <= '0;
            prev     <= '0;
            move_req <= '0;
        end else begin
            sync_a   <= ~buttons;          // pressed reads as 1 from here on
            sync_b   <= sync_a;
            prev     <= sync_b;
            move_req <= sync_b & ~prev;    // rising edge only so held keys move once
        end
    end

endmodule

// File: verilog/wall_map.sv
`timescale 1ns/1ps

// blocked bits are 0 right, 1 down, 2 left, 3 up
module wall_map (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                wb_cyc,
    input  logic                                wb_stb,
    input  logic                                wb_we,
    input  logic [maze_grid_pkg::wall_addr_w-1:0] wb_adr,
    input  maze_grid_pkg::wb_data_t             wb_dat_w,
    output maze_grid_pkg::wb_data_t             wb_dat_r,
    output logic                                wb_ack,
    input  maze_grid_pkg::cell_x_t              cur_x,
    input  maze_grid_pkg::cell_y_t              cur_y,
    output logic [3:0]                          blocked
);

    logic [maze_grid_pkg::h_row_bits-1:0] h_wall [maze_grid_pkg::h_rows];
    logic [maze_grid_pkg::v_row_bits-1:0] v_wall [maze_grid_pkg::v_rows];

    logic                    bus_req;
    logic                    is_h;
    logic                    is_v;
    logic [3:0]              h_idx;
    logic [3:0]              v_idx;
    maze_grid_pkg::wb_data_t rd_word;
    maze_grid_pkg::cell_x_t  x_right;
    maze_grid_pkg::cell_y_t  y_below;

    assign bus_req = wb_cyc && wb_stb && !wb_ack;   // one ack per strobe

    // address decode
    assign is_h  = int'(wb_adr) < maze_grid_pkg::h_rows;
    assign is_v  = int'(wb_adr) >= maze_grid_pkg::v_base &&
                   int'(wb_adr) < maze_grid_pkg::v_base + maze_grid_pkg::v_rows;
    assign h_idx = 4'(wb_adr);
    assign v_idx = 4'(wb_adr - maze_grid_pkg::wall_addr_w'(maze_grid_pkg::v_base));

    always_comb begin
        rd_word = '0;                                  // unused words read zero
        if (is_h)
            rd_word = maze_grid_pkg::wb_data_t'(h_wall[h_idx]);
        else if (is_v)
            rd_word = maze_grid_pkg::wb_data_t'(v_wall[v_idx]);
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < maze_grid_pkg::h_rows; i++)
                h_wall[i] <= '0;
            for (int i = 0; i < maze_grid_pkg::v_rows; i++)
                v_wall[i] <= '0;
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= bus_req;
            if (bus_req && wb_we) begin
                if (is_h)
                    h_wall[h_idx] <= wb_dat_w[maze_grid_pkg::h_row_bits-1:0];
                else if (is_v)
                    v_wall[v_idx] <= wb_dat_w[maze_grid_pkg::v_row_bits-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bus_req)
            wb_dat_r <= rd_word;   // valid while ack is high
    end

    // walls around the player cell
    assign x_right = cur_x + 1'b1;
    assign y_below = cur_y + 1'b1;

    assign blocked[0] = v_wall[cur_y][x_right];
    assign blocked[1] = h_wall[y_below][cur_x];
    assign blocked[2] = v_wall[cur_y][cur_x];
    assign blocked[3] = h_wall[cur_y][cur_x];

endmodule

// File: verilog/player_mover.sv
`timescale 1ns/1ps

module player_mover (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [3:0]             move_req,     // one-hot pulses, bit 0 right
    input  logic [3:0]             blocked,
    input  logic                   drawer_ready,
    output maze_grid_pkg::cell_x_t cur_x,
    output maze_grid_pkg::cell_y_t cur_y,
    output logic                   draw_req,
    output logic                   draw_floor,
    output maze_grid_pkg::cell_x_t draw_x,
    output maze_grid_pkg::cell_y_t draw_y
);

    // init paints the start cell, new paints the cell just entered
    typedef enum logic [1:0] {
        st_init,
        st_play,
        st_new
    } mover_state_t;

    mover_state_t           state;
    logic [3:0]             pick;
    logic [3:0]             open_dir;
    logic                   go;
    maze_grid_pkg::cell_x_t nxt_x;
    maze_grid_pkg::cell_y_t nxt_y;

    // lower bit wins the fixed priority
    always_comb begin
        pick = 4'b0000;
        if (move_req[0])
            pick = 4'b0001;
        else if (move_req[1])
            pick = 4'b0010;
        else if (move_req[2])
            pick = 4'b0100;
        else if (move_req[3])
            pick = 4'b1000;
    end

    // grid edges refuse a move even without a wall bit
    assign open_dir[0] = !blocked[0] &&
                         cur_x != maze_grid_pkg::cell_x_t'(maze_grid_pkg::grid_cols - 1);
    assign open_dir[1] = !blocked[1] &&
                         cur_y != maze_grid_pkg::cell_y_t'(maze_grid_pkg::grid_rows - 1);
    assign open_dir[2] = !blocked[2] && cur_x != '0;
    assign open_dir[3] = !blocked[3] && cur_y != '0;

    // no accept while a request is still landing in the drawer
    assign go = state == st_play && drawer_ready && !draw_req && |(pick & open_dir);

    always_comb begin
        nxt_x = cur_x;
        nxt_y = cur_y;
        if (pick[0])
            nxt_x = cur_x + 1'b1;
        else if (pick[1])
            nxt_y = cur_y + 1'b1;
        else if (pick[2])
            nxt_x = cur_x - 1'b1;
        else if (pick[3])
            nxt_y = cur_y - 1'b1;
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state    <= st_init;
            cur_x    <= '0;
            cur_y    <= '0;
            draw_req <= 1'b0;
        end else begin
            draw_req <= 1'b0;
            case (state)
                st_init: begin
                    if (drawer_ready) begin
                        draw_req <= 1'b1;
                        state    <= st_play;
                    end
                end
                st_play: begin
                    if (go) begin
                        draw_req <= 1'b1;   // erase of the old cell
                        cur_x    <= nxt_x;
                        cur_y    <= nxt_y;
                        state    <= st_new;
                    end
                end
                st_new: begin
                    if (drawer_ready) begin
                        draw_req <= 1'b1;
                        state    <= st_play;
                    end
                end
                default: state <= st_init;
            endcase
        end
    end

    // in st_play the old cell is latched next to the erase pulse
    always_ff @(posedge clk) begin
        draw_floor <= state == st_play;
        draw_x     <= cur_x;
        draw_y     <= cur_y;
    end

endmodule

// File: verilog/cell_drawer.sv
`timescale 1ns/1ps

module cell_drawer (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   draw_req,
    input  logic                   draw_floor,
    input  maze_grid_pkg::cell_x_t draw_x,
    input  maze_grid_pkg::cell_y_t draw_y,
    output logic                   drawer_ready,
    input  logic                   tx_busy,
    output logic                   tx_start,
    output tft_link_pkg::tft_byte_t tx_byte,
    output logic                   tx_dc
);

    tft_link_pkg::draw_state_t state;
    tft_link_pkg::draw_state_t nxt_state;
    tft_link_pkg::tft_byte_t   nxt_byte;
    logic                      nxt_dc;
    logic                      send;
    logic                      done;

    // act is being emitted, pend waits behind it
    logic                   act_valid;
    logic                   act_floor;
    maze_grid_pkg::cell_x_t act_x;
    maze_grid_pkg::cell_y_t act_y;
    logic                   pend_valid;
    logic                   pend_floor;
    maze_grid_pkg::cell_x_t pend_x;
    maze_grid_pkg::cell_y_t pend_y;

    assign drawer_ready = !(act_valid && pend_valid);

    // busy only rises the edge after start
    assign send = state != tft_link_pkg::idle && !tx_busy && !tx_start;
    assign done = send && state == tft_link_pkg::pixel;

    always_comb begin
        nxt_state = state;
        nxt_byte  = '0;
        nxt_dc    = 1'b1;   // data unless a command below
        case (state)
            tft_link_pkg::idle: begin
                if (act_valid)
                    nxt_state = tft_link_pkg::col_cmd;
            end
            tft_link_pkg::col_cmd: begin
                nxt_byte  = tft_link_pkg::cmd_col_addr;
                nxt_dc    = 1'b0;
                nxt_state = tft_link_pkg::col_arg;
            end
            tft_link_pkg::col_arg: begin
                nxt_byte  = tft_link_pkg::tft_byte_t'(act_x);
                nxt_state = tft_link_pkg::page_cmd;
            end
            tft_link_pkg::page_cmd: begin
                nxt_byte  = tft_link_pkg::cmd_page_addr;
                nxt_dc    = 1'b0;
                nxt_state = tft_link_pkg::page_arg;
            end
            tft_link_pkg::page_arg: begin
                nxt_byte  = tft_link_pkg::tft_byte_t'(act_y);
                nxt_state = tft_link_pkg::write_cmd;
            end
            tft_link_pkg::write_cmd: begin
                nxt_byte  = tft_link_pkg::cmd_mem_write;
                nxt_dc    = 1'b0;
                nxt_state = tft_link_pkg::pixel;
            end
            tft_link_pkg::pixel: begin
                nxt_byte  = act_floor ? tft_link_pkg::colour_floor
                                      : tft_link_pkg::colour_player;
                nxt_state = tft_link_pkg::idle;
            end
            default: nxt_state = tft_link_pkg::idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state      <= tft_link_pkg::idle;
            tx_start   <= 1'b0;
            act_valid  <= 1'b0;
            pend_valid <= 1'b0;
        end else begin
            tx_start <= send;
            if (send || state == tft_link_pkg::idle)
                state <= nxt_state;

            // request slots
            if (done) begin
                act_valid  <= pend_valid || draw_req;
                pend_valid <= pend_valid && draw_req;
            end else if (draw_req) begin
                if (act_valid)
                    pend_valid <= 1'b1;
                else
                    act_valid <= 1'b1;
            end
        end
    end

    // slot payload follows the same decisions as the valid flags
    always_ff @(posedge clk) begin
        if (done && pend_valid) begin
            act_floor <= pend_floor;
            act_x     <= pend_x;
            act_y     <= pend_y;
        end else if (draw_req && (done || !act_valid)) begin
            act_floor <= draw_floor;
            act_x     <= draw_x;
            act_y     <= draw_y;
        end
        if (draw_req && act_valid && (pend_valid || !done)) begin
            pend_floor <= draw_floor;
            pend_x     <= draw_x;
            pend_y     <= draw_y;
        end
        if (send) begin
            tx_byte <= nxt_byte;
            tx_dc   <= nxt_dc;
        end
    end

endmodule

// File: verilog/tft_spi_tx.sv
`timescale 1ns/1ps

module tft_spi_tx (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    tx_start,
    input  tft_link_pkg::tft_byte_t tx_byte,
    input  logic                    tx_dc,
    output logic                    tx_busy,
    output logic                    tft_clk,
    output logic                    tft_mosi,
    output logic                    tft_dc,
    output logic                    tft_cs
);

    tft_link_pkg::spi_state_t state;
    tft_link_pkg::tft_byte_t  shreg;
    logic [3:0]               cnt;   // two counts per bit

    assign tx_busy  = state == tft_link_pkg::spi_shift;
    assign tft_mosi = shreg[7];      // msb first

    always_ff @(posedge clk) begin
        if (!rst) begin
            state   <= tft_link_pkg::spi_idle;
            cnt     <= '0;
            tft_clk <= 1'b0;
            tft_cs  <= 1'b1;
            tft_dc  <= 1'b0;
        end else if (state == tft_link_pkg::spi_idle) begin
            if (tx_start) begin
                state  <= tft_link_pkg::spi_shift;
                cnt    <= '0;
                tft_cs <= 1'b0;
                tft_dc <= tx_dc;     // held for the whole byte
            end
        end else begin
            cnt     <= cnt + 1'b1;
            tft_clk <= !cnt[0];      // rise on even counts, fall on odd
            if (cnt == 4'd15) begin
                tft_cs <= 1'b1;
                state  <= tft_link_pkg::spi_idle;
            end
        end
    end

    // mode 0 puts the next bit out with the falling edge
    always_ff @(posedge clk) begin
        if (state == tft_link_pkg::spi_idle && tx_start)
            shreg <= tx_byte;
        else if (state == tft_link_pkg::spi_shift && cnt[0] && cnt != 4'd15)
            shreg <= shreg << 1;
    end

endmodule

// File: verilog/maze_game.sv
`timescale 1ns/1ps

module maze_game (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic [3:0]                            buttons,   // right, down, left, up
    input  logic                                  wb_cyc,
    input  logic                                  wb_stb,
    input  logic                                  wb_we,
    input  logic [maze_grid_pkg::wall_addr_w-1:0] wb_adr,
    input  maze_grid_pkg::wb_data_t               wb_dat_w,
    output maze_grid_pkg::wb_data_t               wb_dat_r,
    output logic                                  wb_ack,
    output logic                                  tft_clk,
    output logic                                  tft_mosi,
    output logic                                  tft_dc,
    output logic                                  tft_cs
);

    logic [3:0]              move_req;
    logic [3:0]              blocked;
    maze_grid_pkg::cell_x_t  cur_x;
    maze_grid_pkg::cell_y_t  cur_y;
    logic                    drawer_ready;
    logic                    draw_req;
    logic                    draw_floor;
    maze_grid_pkg::cell_x_t  draw_x;
    maze_grid_pkg::cell_y_t  draw_y;
    logic                    tx_busy;
    logic                    tx_start;
    tft_link_pkg::tft_byte_t tx_byte;
    logic                    tx_dc;

    // input side
    button_sampler u_buttons (
        .clk      (clk),
        .rst      (rst),
        .buttons  (buttons),
        .move_req (move_req)
    );

    wall_map u_walls (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .cur_x    (cur_x),
        .cur_y    (cur_y),
        .blocked  (blocked)
    );

    player_mover u_mover (
        .clk          (clk),
        .rst          (rst),
        .move_req     (move_req),
        .blocked      (blocked),
        .drawer_ready (drawer_ready),
        .cur_x        (cur_x),
        .cur_y        (cur_y),
        .draw_req     (draw_req),
        .draw_floor   (draw_floor),
        .draw_x       (draw_x),
        .draw_y       (draw_y)
    );

    // output side
    cell_drawer u_drawer (
        .clk          (clk),
        .rst          (rst),
        .draw_req     (draw_req),
        .draw_floor   (draw_floor),
        .draw_x       (draw_x),
        .draw_y       (draw_y),
        .drawer_ready (drawer_ready),
        .tx_busy      (tx_busy),
        .tx_start     (tx_start),
        .tx_byte      (tx_byte),
        .tx_dc        (tx_dc)
    );

    tft_spi_tx u_spi (
        .clk      (clk),
        .rst      (rst),
        .tx_start (tx_start),
        .tx_byte  (tx_byte),
        .tx_dc    (tx_dc),
        .tx_busy  (tx_busy),
        .tft_clk  (tft_clk),
        .tft_mosi (tft_mosi),
        .tft_dc   (tft_dc),
        .tft_cs   (tft_cs)
    );

endmodule

// File: tb/maze_game_properties.sv
`timescale 1ns/1ps

module maze_game_properties (
    input logic clk,
    input logic rst,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_ack,
    input logic tft_clk,
    input logic tft_cs,
    input logic tft_dc
);

    ack_one_cycle: assert property (@(posedge clk) disable iff (!rst)
        wb_ack |=> !wb_ack)
        else $error("wb_ack held high for two cycles");

    ack_after_strobe: assert property (@(posedge clk) disable iff (!rst)
        wb_ack |-> $past(wb_cyc && wb_stb))
        else $error("wb_ack without a preceding cyc and stb");

    // serial clock parks low between bytes
    clk_idle_low: assert property (@(posedge clk) disable iff (!rst)
        tft_cs |-> !tft_clk)
        else $error("tft_clk high while tft_cs is high");

    dc_steady: assert property (@(posedge clk) disable iff (!rst)
        (!tft_cs && $past(!tft_cs)) |-> $stable(tft_dc))
        else $error("tft_dc changed in the middle of a byte");

endmodule

bind maze_game maze_game_properties u_props (
    .clk     (clk),
    .rst     (rst),
    .wb_cyc  (wb_cyc),
    .wb_stb  (wb_stb),
    .wb_ack  (wb_ack),
    .tft_clk (tft_clk),
    .tft_cs  (tft_cs),
    .tft_dc  (tft_dc)
);

// File: tb/maze_game_tb.sv
`timescale 1ns/1ps

module maze_game_tb;

    localparam int max_cycles  = 30 * 2000;  // about 30 presses with bus traffic and slack
    localparam int idle_cycles = 40;         // quiet link time that ends a press
    localparam logic [3:0] key_right = 4'b0001;
    localparam logic [3:0] key_down  = 4'b0010;
    localparam logic [3:0] key_left  = 4'b0100;
    localparam logic [3:0] key_up    = 4'b1000;

    logic                                  clk;
    logic                                  rst;
    logic [3:0]                            buttons;
    logic                                  wb_cyc;
    logic                                  wb_stb;
    logic                                  wb_we;
    logic [maze_grid_pkg::wall_addr_w-1:0] wb_adr;
    maze_grid_pkg::wb_data_t               wb_dat_w;
    maze_grid_pkg::wb_data_t               wb_dat_r;
    logic                                  wb_ack;
    logic                                  tft_clk;
    logic                                  tft_mosi;
    logic                                  tft_dc;
    logic                                  tft_cs;

    int         seed;
    int         cycles;
    int         mismatches;
    int         other_errors;
    int         ref_x;
    int         ref_y;
    int         ref_h [maze_grid_pkg::h_rows];   // model copy of the wall rows
    int         ref_v [maze_grid_pkg::v_rows];
    logic [8:0] expect_q [$];                    // {dc, byte}
    logic [8:0] got_q [$];
    event       byte_seen;

    maze_game u_dut (
        .clk      (clk),
        .rst      (rst),
        .buttons  (buttons),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .tft_clk  (tft_clk),
        .tft_mosi (tft_mosi),
        .tft_dc   (tft_dc),
        .tft_cs   (tft_cs)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // six link bytes that paint one cell
    function automatic void queue_cell(input int x, input int y, input bit floor);
        expect_q.push_back({1'b0, tft_link_pkg::cmd_col_addr});
        expect_q.push_back({1'b1, 8'(x)});
        expect_q.push_back({1'b0, tft_link_pkg::cmd_page_addr});
        expect_q.push_back({1'b1, 8'(y)});
        expect_q.push_back({1'b0, tft_link_pkg::cmd_mem_write});
        expect_q.push_back({1'b1, floor ? 8'h00 : 8'hFF});
    endfunction

    // reference model where the lowest key bit wins and only that direction is tried
    function automatic void predict_move(input logic [3:0] keys);
        int nx;
        int ny;
        bit can_move;
        nx = ref_x;
        ny = ref_y;
        can_move = 1'b0;
        if (keys[0]) begin
            can_move = ref_x < maze_grid_pkg::grid_cols - 1 &&
                       ((ref_v[ref_y] >> (ref_x + 1)) & 1) == 0;
            nx = ref_x + 1;
        end else if (keys[1]) begin
            can_move = ref_y < maze_grid_pkg::grid_rows - 1 &&
                       ((ref_h[ref_y + 1] >> ref_x) & 1) == 0;
            ny = ref_y + 1;
        end else if (keys[2]) begin
            can_move = ref_x > 0 && ((ref_v[ref_y] >> ref_x) & 1) == 0;
            nx = ref_x - 1;
        end else if (keys[3]) begin
            can_move = ref_y > 0 && ((ref_h[ref_y] >> ref_x) & 1) == 0;
            ny = ref_y - 1;
        end
        if (can_move) begin
            queue_cell(ref_x, ref_y, 1'b1);   // erase first
            queue_cell(nx, ny, 1'b0);
            ref_x = nx;
            ref_y = ny;
        end
    endfunction

    task automatic wb_write(input int addr, input int data);
        @(posedge clk);
        #1;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = maze_grid_pkg::wall_addr_w'(addr);
        wb_dat_w = maze_grid_pkg::wb_data_t'(data);
        do begin
            @(posedge clk);
            #1;
        end while (!wb_ack);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        if (addr < maze_grid_pkg::h_rows)
            ref_h[addr] = data & ((1 << maze_grid_pkg::h_row_bits) - 1);
        else if (addr >= maze_grid_pkg::v_base &&
                 addr < maze_grid_pkg::v_base + maze_grid_pkg::v_rows)
            ref_v[addr - maze_grid_pkg::v_base] = data & ((1 << maze_grid_pkg::v_row_bits) - 1);
    endtask

    task automatic wb_read(input int addr, output int data);
        @(posedge clk);
        #1;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = maze_grid_pkg::wall_addr_w'(addr);
        do begin
            @(posedge clk);
            #1;
        end while (!wb_ack);
        data   = int'(wb_dat_r);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
    endtask

    task automatic check_wall_readback();
        int written [31];
        int got;
        int want;
        for (int i = 0; i < 31; i++) begin
            written[i] = int'(16'($random(seed)));
            wb_write(i, written[i]);
        end
        wb_write(31, 16'hBEEF);   // unused word that drops the write
        for (int i = 0; i < 32; i++) begin
            wb_read(i, got);
            want = 0;
            if (i < maze_grid_pkg::h_rows)
                want = ref_h[i];
            else if (i < maze_grid_pkg::v_base + maze_grid_pkg::v_rows)
                want = ref_v[i - maze_grid_pkg::v_base];
            assert (got == want) else begin
                mismatches++;
                $display("MISMATCH wb_dat_r at address 0x%h: got 0x%h, expected 0x%h",
                         i, got, want);
            end
        end
    endtask

    task automatic load_walls(input bit random_fill);
        for (int i = 0; i < 31; i++)
            wb_write(i, random_fill ? int'(16'($random(seed) & $random(seed))) : 0);
    endtask

    task automatic wait_link_idle();
        int quiet;
        quiet = 0;
        while (quiet < idle_cycles) begin
            @(posedge clk);
            #1;
            if (tft_cs)
                quiet++;
            else
                quiet = 0;
        end
    endtask

    task automatic check_settled(input string what);
        assert (expect_q.size() == 0) else begin
            other_errors++;
            $display("%s: %0d expected link bytes never appeared", what, expect_q.size());
            expect_q.delete();
        end
    endtask

    task automatic tap_keys(input logic [3:0] keys);
        @(posedge clk);
        #1;
        buttons = ~keys;   // active low at the pins
        repeat (4) @(posedge clk);
        #1;
        buttons = 4'hF;
    endtask

    task automatic press(input logic [3:0] keys);
        predict_move(keys);
        tap_keys(keys);
        wait_link_idle();
        check_settled($sformatf("press %b", keys));
    endtask

    // second press lands while the erase of the first is shifting out
    task automatic press_while_busy(input logic [3:0] first, input logic [3:0] second);
        predict_move(first);
        tap_keys(first);
        repeat (20) @(posedge clk);
        tap_keys(second);
        wait_link_idle();
        check_settled("press during a draw");
    endtask

    initial begin : capture_bytes
        int         nbits;
        logic [7:0] shreg;
        nbits = 0;
        shreg = '0;
        forever begin
            @(posedge tft_clk);
            shreg = {shreg[6:0], tft_mosi};   // msb first
            nbits++;
            if (nbits == 8) begin
                got_q.push_back({tft_dc, shreg});
                nbits = 0;
                ->byte_seen;
            end
        end
    end

    initial begin : compare_bytes
        logic [8:0] got;
        logic [8:0] want;
        forever begin
            @(byte_seen);
            while (got_q.size() > 0) begin
                got = got_q.pop_front();
                assert (expect_q.size() > 0) else begin
                    other_errors++;
                    $display("unexpected link byte 0x%h with no draw expected", got[7:0]);
                end
                if (expect_q.size() > 0) begin
                    want = expect_q.pop_front();
                    assert (got[7:0] == want[7:0]) else begin
                        mismatches++;
                        $display("MISMATCH tft_mosi byte: got 0x%h, expected 0x%h",
                                 got[7:0], want[7:0]);
                    end
                    assert (got[8] == want[8]) else begin
                        mismatches++;
                        $display("MISMATCH tft_dc: got 0x%h, expected 0x%h",
                                 got[8], want[8]);
                    end
                end
            end
        end
    end

    initial begin : watchdog
        cycles = 0;
        while (cycles < max_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("run timed out after %0d clock cycles", cycles);
        $display("run stopped: %0d mismatches, %0d other failures", mismatches, other_errors);
        $display("Errors found");
        $finish;
    end

    initial begin : main
        seed         = 43370;
        mismatches   = 0;
        other_errors = 0;
        rst          = 1'b0;
        buttons      = 4'hF;
        wb_cyc       = 1'b0;
        wb_stb       = 1'b0;
        wb_we        = 1'b0;
        wb_adr       = '0;
        wb_dat_w     = '0;
        ref_x        = 0;
        ref_y        = 0;
        for (int i = 0; i < maze_grid_pkg::h_rows; i++)
            ref_h[i] = 0;
        for (int i = 0; i < maze_grid_pkg::v_rows; i++)
            ref_v[i] = 0;

        queue_cell(0, 0, 1'b0);   // start-up draw of the player
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b1;
        wait_link_idle();
        check_settled("start-up draw");

        check_wall_readback();
        load_walls(1'b0);

        // open maze with edges at the origin and on the right
        press(key_up);
        press(key_left);
        repeat (10) press(key_right);
        repeat (2) press(key_down);
        repeat (2) press(key_left);

        press(key_right | key_down);
        press(key_left | key_up);

        press_while_busy(key_right, key_down);

        // player sits at (8,2) with walls above, right and below and the left side open
        wb_write(2, 1 << 8);
        wb_write(maze_grid_pkg::v_base + 2, 1 << 9);
        wb_write(3, 1 << 8);
        press(key_up);
        press(key_right);
        press(key_down);
        press(key_left);

        load_walls(1'b1);
        repeat (10) press(4'(1 << ($random(seed) & 3)));

        $display("run complete: %0d mismatches, %0d other failures", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: maze_game.f
verilog/maze_grid_pkg.sv
verilog/tft_link_pkg.sv
verilog/button_sampler.sv
verilog/wall_map.sv
verilog/player_mover.sv
verilog/cell_drawer.sv
verilog/tft_spi_tx.sv
verilog/maze_game.sv
tb/maze_game_properties.sv
tb/maze_game_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile with Verilator, run, and look for the pass line in the output
verilator --binary --timing --assert -sv --timescale 1ns/1ps \
    -f maze_game.f --top-module maze_game_tb -o maze_game_sim \
    && ./obj_dir/maze_game_sim | tee /dev/stderr | grep "No errors" > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
